// ==== bj_pkg.sv ====
`default_nettype none

package bj_pkg;

	// ------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------
	localparam int card_w  = 4;
	localparam int point_w = 6;
	localparam int cnt_w   = 6;
	localparam int pct_w   = 7;

	// ------------------------------------------------------------------
	// deck and round constants
	// ------------------------------------------------------------------
	localparam int deck_size  = 52;
	localparam int deal_limit = 50;
	localparam int target     = 21;
	localparam int max_point  = 10;
	localparam int round_len  = 10;
	localparam int hand_len   = 5;
	localparam int pct_scale  = 100;

	// entry k holds the number of remaining cards worth k or more
	typedef logic [1:max_point][cnt_w-1:0] deck_table_t;

	localparam deck_table_t deck_init = {
		cnt_w'(deck_size), cnt_w'(36), cnt_w'(32), cnt_w'(28), cnt_w'(24),
		cnt_w'(20), cnt_w'(16), cnt_w'(12), cnt_w'(8), cnt_w'(4)
	};

	typedef struct packed {
		logic              valid;
		logic [card_w-1:0] value;
	} card_evt_t;

	typedef struct packed {
		logic             start;
		logic [cnt_w-1:0] equal_cnt;
		logic [cnt_w-1:0] exceed_cnt;
		logic [cnt_w-1:0] total;
	} prob_req_t;

	typedef struct packed {
		logic valid;
		logic equal;
		logic exceed;
	} prob_bit_t;

	// result: 00 none, 10 player 1, 11 player 2
	typedef struct packed {
		logic       valid;
		logic [1:0] result;
	} win_evt_t;

endpackage

`default_nettype wire

// ==== card_intake.sv ====
`default_nettype none

module card_intake (
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	input  wire logic                      in_valid1,
	input  wire logic                      in_valid2,
	input  wire logic [bj_pkg::card_w-1:0] user1,
	input  wire logic [bj_pkg::card_w-1:0] user2,
	output bj_pkg::card_evt_t              card
);
	import bj_pkg::*;

	logic [card_w-1:0] sel;
	logic              valid_q;
	logic [card_w-1:0] value_q;

	// user1 has priority on a shared strobe
	assign sel = in_valid1 ? user1 : user2;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= in_valid1 | in_valid2;
		end
	end

	// face cards count as 1
	always_ff @(posedge clk) begin
		if (in_valid1 || in_valid2) begin
			value_q <= (sel > card_w'(max_point)) ? card_w'(1) : sel;
		end
	end

	assign card = '{valid: valid_q, value: value_q};

	a_rank_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		(in_valid1 || in_valid2) |-> sel != '0);

endmodule

`default_nettype wire

// ==== deck_tracker.sv ====
`default_nettype none

module deck_tracker (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire bj_pkg::card_evt_t card,
	output bj_pkg::deck_table_t    tbl
);
	import bj_pkg::*;

	logic [cnt_w-1:0] dealt;
	logic             refill;
	deck_table_t      base;
	deck_table_t      tbl_nxt;

	// ------------------------------------------------------------------
	// refill and decrement
	// ------------------------------------------------------------------

	// fresh deck once deal_limit cards are gone
	assign refill = (dealt == cnt_w'(deal_limit));

	always_comb begin
		base    = refill ? deck_init : tbl;
		tbl_nxt = base;
		// a card of value v sits in every entry up to v
		for (int k = 1; k <= max_point; k++) begin
			if (card_w'(k) <= card.value) begin
				tbl_nxt[k] = base[k] - 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tbl   <= deck_init;
			dealt <= '0;
		end else if (card.valid) begin
			tbl <= tbl_nxt;
			if (refill) begin
				dealt <= cnt_w'(1);
			end else begin
				dealt <= dealt + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------

	// entries fall with k so the entry at the card value is the smallest touched
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		card.valid |-> base[card.value] != '0);

endmodule

`default_nettype wire

// ==== game_ctrl.sv ====
`default_nettype none

module game_ctrl (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire bj_pkg::card_evt_t   card,
	input  wire bj_pkg::deck_table_t tbl,
	input  wire logic                busy,
	output bj_pkg::prob_req_t        req,
	output bj_pkg::win_evt_t         win
);
	import bj_pkg::*;

	logic [card_w-1:0]  pos;
	logic [card_w-1:0]  pos_nxt;
	logic [card_w-1:0]  hand_idx;
	logic [point_w-1:0] p1;
	logic [point_w-1:0] p2;
	logic [point_w-1:0] p2_nxt;
	logic [point_w-1:0] pts;
	logic [card_w-1:0]  need;
	logic [cnt_w-1:0]   eq_cnt;
	logic [cnt_w-1:0]   ex_cnt;
	logic [1:0]         win_res;
	logic               calc_pend;
	logic               start_q;
	logic [cnt_w-1:0]   eq_q;
	logic [cnt_w-1:0]   ex_q;
	logic [cnt_w-1:0]   tot_q;
	logic               win_valid_q;
	logic [1:0]         win_res_q;

	// ------------------------------------------------------------------
	// card position and points
	// ------------------------------------------------------------------
	assign pos_nxt  = (pos == card_w'(round_len) || pos == '0) ? card_w'(1) : pos + 1'b1;
	assign hand_idx = (pos_nxt > card_w'(hand_len)) ? pos_nxt - card_w'(hand_len) : pos_nxt;
	assign p2_nxt   = (pos_nxt == card_w'(hand_len + 1)) ? point_w'(card.value)
	                                                     : p2 + point_w'(card.value);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos       <= '0;
			p1        <= '0;
			p2        <= '0;
			calc_pend <= 1'b0;
		end else begin
			calc_pend <= card.valid &&
			             (hand_idx == card_w'(hand_len - 2) ||
			              hand_idx == card_w'(hand_len - 1));
			if (card.valid) begin
				pos <= pos_nxt;
				if (pos_nxt == card_w'(1)) begin
					p1 <= point_w'(card.value);
				end else if (pos_nxt <= card_w'(hand_len)) begin
					p1 <= p1 + point_w'(card.value);
				end else begin
					p2 <= p2_nxt;
				end
			end
		end
	end

	// ------------------------------------------------------------------
	// probability request
	// ------------------------------------------------------------------
	always_comb begin
		pts    = (pos <= card_w'(hand_len)) ? p1 : p2;
		need   = card_w'(target - pts);
		eq_cnt = '0;
		ex_cnt = '0;
		if (pts > point_w'(max_point) && pts < point_w'(target)) begin
			eq_cnt = tbl[need];
			if (need < card_w'(max_point)) begin
				eq_cnt = tbl[need] - tbl[need + 1'b1];
			end
		end
		if (pts >= point_w'(target)) begin
			ex_cnt = tbl[1];
		end else if (pts > point_w'(max_point + 1)) begin
			// smallest card that busts is 22 - points
			ex_cnt = tbl[card_w'(target + 1 - pts)];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			start_q <= 1'b0;
		end else begin
			start_q <= calc_pend;
		end
	end

	always_ff @(posedge clk) begin
		if (calc_pend) begin
			eq_q  <= eq_cnt;
			ex_q  <= ex_cnt;
			tot_q <= tbl[1];
		end
	end

	assign req = '{start: start_q, equal_cnt: eq_q, exceed_cnt: ex_q, total: tot_q};

	// ------------------------------------------------------------------
	// winner at card 10
	// ------------------------------------------------------------------
	always_comb begin
		if (p1 > point_w'(target) && p2_nxt > point_w'(target)) begin
			win_res = 2'b00;
		end else if (p1 > point_w'(target)) begin
			win_res = 2'b11;
		end else if (p2_nxt > point_w'(target) || p1 > p2_nxt) begin
			win_res = 2'b10;
		end else if (p2_nxt > p1) begin
			win_res = 2'b11;
		end else begin
			win_res = 2'b00;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			win_valid_q <= 1'b0;
		end else begin
			win_valid_q <= card.valid && pos_nxt == card_w'(round_len);
		end
	end

	always_ff @(posedge clk) begin
		win_res_q <= win_res;
	end

	assign win = '{valid: win_valid_q, result: win_res_q};

	// no new card while a percentage is pending or streaming
	a_card_spacing: assert property (@(posedge clk) disable iff (!rst_n)
		card.valid |-> !(busy || calc_pend || start_q));

endmodule

`default_nettype wire

// ==== prob_divider.sv ====
`default_nettype none

module prob_divider (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire bj_pkg::prob_req_t req,
	output bj_pkg::prob_bit_t      bits,
	output logic                   busy
);
	import bj_pkg::*;

	logic [cnt_w+pct_w-1:0] eq_rem;
	logic [cnt_w+pct_w-1:0] ex_rem;
	logic [cnt_w+pct_w-1:0] div_q;
	logic [2:0]             bit_cnt;
	logic                   run;
	logic                   eq_ge;
	logic                   ex_ge;
	logic                   valid_q;
	logic                   equal_q;
	logic                   exceed_q;

	assign eq_ge = (eq_rem >= div_q);
	assign ex_ge = (ex_rem >= div_q);

	// ------------------------------------------------------------------
	// control
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run      <= 1'b0;
			bit_cnt  <= '0;
			valid_q  <= 1'b0;
			equal_q  <= 1'b0;
			exceed_q <= 1'b0;
		end else begin
			valid_q  <= run;
			equal_q  <= run && eq_ge;
			exceed_q <= run && ex_ge;
			if (req.start) begin
				run     <= 1'b1;
				bit_cnt <= '0;
			end else if (run) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 3'(pct_w - 1)) begin
					run <= 1'b0;
				end
			end
		end
	end

	// ------------------------------------------------------------------
	// restoring division, msb first
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (req.start) begin
			eq_rem <= (cnt_w+pct_w)'(req.equal_cnt * pct_scale);
			ex_rem <= (cnt_w+pct_w)'(req.exceed_cnt * pct_scale);
			// divisor starts at the weight of quotient bit 6
			div_q  <= (cnt_w+pct_w)'(req.total) << (pct_w - 1);
		end else if (run) begin
			if (eq_ge) begin
				eq_rem <= eq_rem - div_q;
			end
			if (ex_ge) begin
				ex_rem <= ex_rem - div_q;
			end
			div_q <= div_q >> 1;
		end
	end

	assign bits = '{valid: valid_q, equal: equal_q, exceed: exceed_q};
	assign busy = run | valid_q;

	// quotient must stay within 100
	a_count_le_total: assert property (@(posedge clk) disable iff (!rst_n)
		req.start |-> (req.equal_cnt <= req.total && req.exceed_cnt <= req.total));

endmodule

`default_nettype wire

// ==== result_serializer.sv ====
`default_nettype none

module result_serializer (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire bj_pkg::prob_bit_t bits,
	input  wire bj_pkg::win_evt_t  win,
	output logic                   out_valid1,
	output logic                   equal,
	output logic                   exceed,
	output logic                   out_valid2,
	output logic                   winner
);

	logic win_left;
	logic win_res_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid1 <= 1'b0;
			equal      <= 1'b0;
			exceed     <= 1'b0;
		end else begin
			out_valid1 <= bits.valid;
			equal      <= bits.valid & bits.equal;
			exceed     <= bits.valid & bits.exceed;
		end
	end

	// winner bits run 1 then 0 for player 1 and 1 then 1 for player 2
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid2 <= 1'b0;
			winner     <= 1'b0;
			win_left   <= 1'b0;
		end else if (win.valid) begin
			out_valid2 <= 1'b1;
			winner     <= win.result[1];
			win_left   <= win.result[1];
		end else if (win_left) begin
			out_valid2 <= 1'b1;
			winner     <= win_res_q;
			win_left   <= 1'b0;
		end else begin
			out_valid2 <= 1'b0;
			winner     <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (win.valid) begin
			win_res_q <= win.result[0];
		end
	end

	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		!(bits.valid && (win.valid || win_left)));

endmodule

`default_nettype wire

// ==== bj_top.sv ====
`default_nettype none

module bj_top (
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	input  wire logic                      in_valid1,
	input  wire logic                      in_valid2,
	input  wire logic [bj_pkg::card_w-1:0] user1,
	input  wire logic [bj_pkg::card_w-1:0] user2,
	output logic                           out_valid1,
	output logic                           out_valid2,
	output logic                           equal,
	output logic                           exceed,
	output logic                           winner
);
	import bj_pkg::*;

	card_evt_t   card;
	deck_table_t tbl;
	prob_req_t   req;
	prob_bit_t   bits;
	win_evt_t    win;
	logic        busy;

	// ------------------------------------------------------------------
	// datapath: intake -> deck / control -> divider -> output
	// ------------------------------------------------------------------
	card_intake card_intake_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid1 (in_valid1),
		.in_valid2 (in_valid2),
		.user1     (user1),
		.user2     (user2),
		.card      (card)
	);

	deck_tracker deck_tracker_inst (.clk(clk), .rst_n(rst_n), .card(card), .tbl(tbl));

	game_ctrl game_ctrl_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.card  (card),
		.tbl   (tbl),
		.busy  (busy),
		.req   (req),
		.win   (win)
	);

	prob_divider prob_divider_inst (.clk(clk), .rst_n(rst_n), .req(req), .bits(bits), .busy(busy));

	result_serializer result_serializer_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.bits       (bits),
		.win        (win),
		.out_valid1 (out_valid1),
		.equal      (equal),
		.exceed     (exceed),
		.out_valid2 (out_valid2),
		.winner     (winner)
	);

endmodule

`default_nettype wire

// ==== tb_bj_top.sv ====
`default_nettype none

module tb_bj_top;
	import bj_pkg::*;

	// sel picks user1 (1), user2 (2) or both strobes with a decoy on user2 (3)
	typedef struct packed {
		logic [1:0]        sel;
		logic [card_w-1:0] rank;
		logic [pct_w-1:0]  eq;
		logic [pct_w-1:0]  ex;
		logic [1:0]        win;
	} card_row_t;

	localparam card_row_t rows [0:29] = '{
		// round 1 on a fresh deck where player 2 wins 21 to 20
		'{2'd1, 4'd10, 7'd0, 7'd0, 2'd0}, '{2'd2, 4'd13, 7'd0, 7'd0, 2'd0},
		'{2'd3, 4'd5, 7'd6, 7'd38, 2'd0}, '{2'd1, 4'd11, 7'd8, 7'd45, 2'd0},
		'{2'd2, 4'd3, 7'd0, 7'd0, 2'd0}, '{2'd2, 4'd9, 7'd0, 7'd0, 2'd0},
		'{2'd1, 4'd2, 7'd0, 7'd0, 2'd0}, '{2'd1, 4'd7, 7'd6, 7'd54, 2'd0},
		'{2'd2, 4'd12, 7'd6, 7'd62, 2'd0}, '{2'd1, 4'd2, 7'd0, 7'd0, 2'd3},
		// round 2 has low totals then a busted player 2
		'{2'd1, 4'd2, 7'd0, 7'd0, 2'd0}, '{2'd2, 4'd3, 7'd0, 7'd0, 2'd0},
		'{2'd1, 4'd4, 7'd0, 7'd0, 2'd0}, '{2'd2, 4'd1, 7'd0, 7'd0, 2'd0},
		'{2'd1, 4'd10, 7'd0, 7'd0, 2'd0}, '{2'd2, 4'd10, 7'd0, 7'd0, 2'd0},
		'{2'd1, 4'd8, 7'd0, 7'd0, 2'd0}, '{2'd2, 4'd9, 7'd0, 7'd100, 2'd0},
		'{2'd1, 4'd13, 7'd0, 7'd100, 2'd0}, '{2'd2, 4'd5, 7'd0, 7'd0, 2'd2},
		// round 3 after the refill ends in a tie at 20
		'{2'd1, 4'd6, 7'd0, 7'd0, 2'd0}, '{2'd2, 4'd5, 7'd0, 7'd0, 2'd0},
		'{2'd2, 4'd1, 7'd8, 7'd8, 2'd0}, '{2'd1, 4'd7, 7'd8, 7'd60, 2'd0},
		'{2'd2, 4'd1, 7'd0, 7'd0, 2'd0}, '{2'd1, 4'd10, 7'd0, 7'd0, 2'd0},
		'{2'd2, 4'd1, 7'd0, 7'd0, 2'd0}, '{2'd3, 4'd11, 7'd9, 7'd6, 2'd0},
		'{2'd1, 4'd7, 7'd9, 7'd62, 2'd0}, '{2'd2, 4'd12, 7'd0, 7'd0, 2'd0}
	};

	logic              clk;
	logic              rst_n;
	logic              in_valid1;
	logic              in_valid2;
	logic [card_w-1:0] user1;
	logic [card_w-1:0] user2;
	logic              out_valid1;
	logic              out_valid2;
	logic              equal;
	logic              exceed;
	logic              winner;

	// reference model state with cards left per point value
	int deck_cnt [1:10];
	int dealt;
	int pos;
	int p1;
	int p2;

	bj_top bj_top_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid1  (in_valid1),
		.in_valid2  (in_valid2),
		.user1      (user1),
		.user2      (user2),
		.out_valid1 (out_valid1),
		.out_valid2 (out_valid2),
		.equal      (equal),
		.exceed     (exceed),
		.winner     (winner)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// ------------------------------------------------------------------
	// failure reporting and compare
	// ------------------------------------------------------------------
	task automatic fail_stop(input string what);
		$display("%s", what);
		$display("STATUS: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input int exp, input int act);
		if (exp != act) begin
			fail_stop($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
		end
	endtask

	// ------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------

	// four each of 2 to 10 and everything else counts as 1
	function automatic void refill_deck();
		for (int v = 1; v <= max_point; v++) begin
			deck_cnt[v] = (v == 1) ? deck_size - 4 * (max_point - 1) : 4;
		end
		dealt = 0;
	endfunction

	function automatic void model_deal(input int value);
		if (dealt == deal_limit) begin
			refill_deck();
		end
		deck_cnt[value]--;
		dealt++;
		pos = (pos == round_len) ? 1 : pos + 1;
		if (pos == 1) begin
			p1 = value;
		end else if (pos <= hand_len) begin
			p1 += value;
		end else if (pos == hand_len + 1) begin
			p2 = value;
		end else begin
			p2 += value;
		end
	endfunction

	function automatic int remaining(input int from_v);
		int sum;
		sum = 0;
		for (int v = from_v; v <= max_point; v++) begin
			sum += deck_cnt[v];
		end
		return sum;
	endfunction

	function automatic int equal_pct();
		int pts;
		pts = (pos <= hand_len) ? p1 : p2;
		if (pts <= max_point || pts >= target) begin
			return 0;
		end
		return deck_cnt[target - pts] * pct_scale / remaining(1);
	endfunction

	function automatic int exceed_pct();
		int pts;
		pts = (pos <= hand_len) ? p1 : p2;
		if (pts >= target) begin
			return pct_scale;
		end
		if (pts <= max_point + 1) begin
			return 0;
		end
		return remaining(target + 1 - pts) * pct_scale / remaining(1);
	endfunction

	function automatic int winner_code();
		if (p1 > target && p2 > target) begin
			return 0;
		end
		if (p1 > target || (p2 <= target && p2 > p1)) begin
			return 3;
		end
		return (p2 > target || p1 > p2) ? 2 : 0;
	endfunction

	// draw from what is really left so the deck never runs dry
	function automatic int draw_value(input int min_v);
		int pick;
		int v;
		pick = int'($urandom % remaining(min_v));
		v = min_v;
		while (pick >= deck_cnt[v]) begin
			pick -= deck_cnt[v];
			v++;
		end
		return v;
	endfunction

	function automatic int rank_for(input int value);
		int r;
		r = int'($urandom % 4);
		if (value != 1) begin
			return value;
		end
		return (r == 0) ? 1 : 10 + r;
	endfunction

	// ------------------------------------------------------------------
	// stimulus and response
	// ------------------------------------------------------------------
	task automatic drive_card(input int sel, input int rank);
		@(posedge clk);
		in_valid1 <= sel[0];
		in_valid2 <= sel[1];
		user1     <= card_w'(rank);
		user2     <= (sel == 3) ? card_w'(2) : card_w'(rank);
		@(posedge clk);
		in_valid1 <= 1'b0;
		in_valid2 <= 1'b0;
	endtask

	task automatic wait_valid(input int which, input string name, inout int spent);
		int tries;
		tries = 0;
		@(negedge clk);
		spent++;
		while (((which == 1) ? out_valid1 : out_valid2) !== 1'b1) begin
			if (tries == 20) begin
				fail_stop($sformatf("%s: out_valid%0d never rose within 20 cycles", name, which));
			end
			tries++;
			@(negedge clk);
			spent++;
		end
	endtask

	task automatic play_card(input string name, input int sel, input int rank);
		int spent;
		int exp_win;
		logic [pct_w-1:0] eq_bits;
		logic [pct_w-1:0] ex_bits;
		spent = 0;
		eq_bits = '0;
		ex_bits = '0;
		drive_card(sel, rank);
		if (pos % hand_len == 3 || pos % hand_len == 4) begin
			wait_valid(1, name, spent);
			for (int b = 0; b < pct_w; b++) begin
				if (b > 0) begin
					@(negedge clk);
					spent++;
				end
				check_value({name, " out_valid1 width"}, 1, int'(out_valid1));
				eq_bits = {eq_bits[pct_w-2:0], equal};
				ex_bits = {ex_bits[pct_w-2:0], exceed};
			end
			check_value({name, " equal"}, equal_pct(), int'(eq_bits));
			check_value({name, " exceed"}, exceed_pct(), int'(ex_bits));
		end else if (pos == round_len) begin
			exp_win = winner_code();
			wait_valid(2, name, spent);
			check_value({name, " winner first"}, exp_win >> 1, int'(winner));
			if (exp_win >= 2) begin
				@(negedge clk);
				spent++;
				check_value({name, " out_valid2 width"}, 1, int'(out_valid2));
				check_value({name, " winner second"}, exp_win & 1, int'(winner));
			end
		end
		// rest of the slot stays quiet
		while (spent < 13) begin
			@(negedge clk);
			spent++;
			check_value({name, " idle out_valid1"}, 0, int'(out_valid1));
			check_value({name, " idle out_valid2"}, 0, int'(out_valid2));
		end
	endtask

	task automatic play_row(input int idx);
		string name;
		card_row_t row;
		name = $sformatf("table card %0d", idx + 1);
		row = rows[idx];
		model_deal((row.rank > max_point) ? 1 : int'(row.rank));
		if (pos % hand_len == 3 || pos % hand_len == 4) begin
			check_value({name, " table equal"}, int'(row.eq), equal_pct());
			check_value({name, " table exceed"}, int'(row.ex), exceed_pct());
		end else if (pos == round_len) begin
			check_value({name, " table winner"}, int'(row.win), winner_code());
		end
		play_card(name, int'(row.sel), int'(row.rank));
	endtask

	task automatic play_random(input int idx);
		int value;
		int sel;
		int min_v;
		// first random round deals only 5 and up so both hands bust
		min_v = (idx < round_len) ? 5 : 1;
		value = draw_value(min_v);
		sel = 1 + int'($urandom % 3);
		model_deal(value);
		play_card($sformatf("random card %0d", idx + 1), sel, rank_for(value));
	endtask

	initial begin
		void'($urandom(32'h999a));
		rst_n     = 1'b0;
		in_valid1 = 1'b0;
		in_valid2 = 1'b0;
		user1     = '0;
		user2     = '0;
		pos       = 0;
		p1        = 0;
		p2        = 0;
		refill_deck();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("reset out_valid1", 0, int'(out_valid1));
		check_value("reset out_valid2", 0, int'(out_valid2));

		// two table rounds and 30 random cards reach card 50 before a round on a fresh deck
		for (int i = 0; i < 2 * round_len; i++) begin
			play_row(i);
		end
		for (int c = 0; c < 3 * round_len; c++) begin
			play_random(c);
		end
		for (int i = 2 * round_len; i < 3 * round_len; i++) begin
			play_row(i);
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
bj_pkg.sv
card_intake.sv
deck_tracker.sv
game_ctrl.sv
prob_divider.sv
result_serializer.sv
bj_top.sv
tb_bj_top.sv

// ==== Makefile ====
SRCS = bj_pkg.sv card_intake.sv deck_tracker.sv game_ctrl.sv prob_divider.sv \
	result_serializer.sv bj_top.sv tb_bj_top.sv

.PHONY: all run clean

all: run

obj_dir/Vtb_bj_top: src.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_bj_top -f src.f -o Vtb_bj_top

run: obj_dir/Vtb_bj_top
	@out="$$(./obj_dir/Vtb_bj_top 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir
